// ==== logic/frameSequencer.sv ====
// SiFH frame sequencer: tags each written sample with its pixel and the frame end
`timescale 1ns/1ps
`include "sifh_defs.svh"
`default_nettype none

module frameSequencer import sifhPkg::*; (
    input  logic    clk,
    input  logic    combin_res,
    input  logic    wrEn,
    input  stamp_t  data,
    output photon_t photon,
    output logic    photonValid
);

    // position of the incoming sample inside the frame
    logic [`SAMPLE_W-1:0] sampleCnt;
    pixelIdx_t            pixelCnt;
    logic [`ACQ_W-1:0]    acqCnt;

    logic lastSample;
    logic lastPixel;
    logic lastAcq;

    // wrap points of each counter
    assign lastSample = (sampleCnt == `SAMPLE_W'(`DATA_NUM - 1));
    assign lastPixel  = (pixelCnt == `PIXEL_W'(`PIXEL_NUM - 1));
    assign lastAcq    = (acqCnt == `ACQ_W'(`ACQ_NUM - 1));

    // **************************************************
    // counters, order is sample then pixel then acq
    // **************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt   <= '0;
            pixelCnt    <= '0;
            acqCnt      <= '0;
            photonValid <= 1'b0;
        end else begin
            photonValid <= wrEn;
            if (wrEn) begin
                if (lastSample) begin
                    sampleCnt <= '0;
                    if (lastPixel) begin
                        pixelCnt <= '0;
                        // acquisition wraps at the frame end
                        acqCnt <= lastAcq ? '0 : acqCnt + 1'b1;
                    end else begin
                        pixelCnt <= pixelCnt + 1'b1;
                    end
                end else begin
                    sampleCnt <= sampleCnt + 1'b1;
                end
            end
        end
    end

    // sample register, only loaded on a write
    always_ff @(posedge clk) begin
        if (wrEn) begin
            photon.pixel    <= pixelCnt;
            photon.stamp    <= data;
            // last sample of last pixel of last acq
            photon.frameEnd <= lastSample && lastPixel && lastAcq;
        end
    end

endmodule

`default_nettype wire

// ==== logic/histBank.sv ====
// SiFH histogram bank: per-pixel bin counts with lazy clear and peak tracking
`timescale 1ns/1ps
`include "sifh_defs.svh"
`default_nettype none

module histBank import sifhPkg::*; #(
    parameter type binIdx_t = coarseBin_t,
    parameter int  BIN_NUM  = 8
) (
    input  logic                           clk,
    input  logic                           combin_res,
    input  logic                           hit,
    input  pixelIdx_t                      pixel,
    input  binIdx_t                        bin,
    input  logic                           frameEnd,
    input  logic                           eventValid,
    output binIdx_t [`PIXEL_NUM-1:0]       peaks,
    output logic                           peaksValid
);

    localparam int ENTRY_NUM = `PIXEL_NUM * BIN_NUM;
    localparam int IDX_W     = $clog2(ENTRY_NUM);

    // **************************************************
    // storage
    // **************************************************

    // one count per pixel and bin
    count_t counts [ENTRY_NUM];
    // entry holds a count of this frame
    logic [ENTRY_NUM-1:0] entryValid;

    // running maximum and its bin per pixel
    count_t  runMax [`PIXEL_NUM];
    binIdx_t runBin [`PIXEL_NUM];

    logic [IDX_W-1:0] entryIdx;
    count_t           curCount;
    count_t           newCount;
    logic             newPeak;
    logic             doHit;
    logic             doClose;

    assign doHit   = eventValid && hit;
    assign doClose = eventValid && frameEnd;

    // flat entry address, pixel major
    assign entryIdx = IDX_W'(pixel) * IDX_W'(BIN_NUM) + IDX_W'(bin);

    // stale entries read as zero, so a first hit writes one
    assign curCount = entryValid[entryIdx] ? counts[entryIdx] : '0;
    assign newCount = curCount + 1'b1;

    // strictly greater, so ties keep the earlier bin
    assign newPeak = doHit && (newCount > runMax[pixel]);

    // **************************************************
    // control state
    // **************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            entryValid <= '0;
            peaksValid <= 1'b0;
            for (int p = 0; p < `PIXEL_NUM; p++) begin
                runMax[p] <= '0;
                runBin[p] <= '0;
            end
        end else begin
            peaksValid <= doClose;
            if (doHit) begin
                entryValid[entryIdx] <= 1'b1;
            end
            if (newPeak) begin
                runMax[pixel] <= newCount;
                runBin[pixel] <= bin;
            end
            // frame end clears everything in the same edge
            // later assignments win over the hit update above
            if (doClose) begin
                entryValid <= '0;
                for (int p = 0; p < `PIXEL_NUM; p++) begin
                    runMax[p] <= '0;
                    runBin[p] <= '0;
                end
            end
        end
    end

    // counts and reported peaks
    always_ff @(posedge clk) begin
        if (doHit) begin
            counts[entryIdx] <= newCount;
        end
        if (doClose) begin
            for (int p = 0; p < `PIXEL_NUM; p++) begin
                // last hit of the frame may still move the peak
                if (newPeak && (pixel == pixelIdx_t'(p))) begin
                    peaks[p] <= bin;
                end else begin
                    peaks[p] <= runBin[p];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/peakResolver.sv ====
// SiFH peak resolver: coarse peaks to next windows, fine peaks to final stamps
`timescale 1ns/1ps
`include "sifh_defs.svh"
`default_nettype none

module peakResolver import sifhPkg::*; (
    input  logic         clk,
    input  logic         combin_res,
    input  coarsePeaks_t coarsePeaks,
    input  finePeaks_t   finePeaks,
    input  logic         peaksValid,
    output windows_t     windows,
    output results_t     result,
    output logic         resultValid
);

    windows_t nextWindows;
    results_t nextResult;
    // no window set yet
    logic     firstFrame;

    // **************************************************
    // window and result rules
    // **************************************************
    always_comb begin
        stamp_t centre;
        stamp_t low;
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            // middle of the coarse peak bin
            centre = stamp_t'(coarsePeaks[p] * `COARSE_SPAN + `COARSE_SPAN / 2);
            // half a window below the centre
            if (centre < stamp_t'(`FINE_SPAN / 2)) begin
                low = '0;
            end else begin
                low = centre - stamp_t'(`FINE_SPAN / 2);
            end
            // keep the window inside the stamp range
            if (low > stamp_t'(`WINDOW_MAX)) begin
                low = stamp_t'(`WINDOW_MAX);
            end
            nextWindows[p] = low;

            // centre of the fine bin: low + 2 * bin + 1
            nextResult[p] = windows[p] + stamp_t'({finePeaks[p], 1'b1});
        end
    end

    // windows and result load on the same edge
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            windows     <= '0;
            result      <= '0;
            resultValid <= 1'b0;
            firstFrame  <= 1'b1;
        end else begin
            resultValid <= peaksValid && !firstFrame;
            if (peaksValid) begin
                windows    <= nextWindows;
                firstFrame <= 1'b0;
                // the first frame had no window to resolve against
                if (!firstFrame) begin
                    result <= nextResult;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/photonBinner.sv ====
// SiFH photon binner: filters empty samples and maps photons to coarse and fine bins
`timescale 1ns/1ps
`include "sifh_defs.svh"
`default_nettype none

module photonBinner import sifhPkg::*; (
    input  logic         clk,
    input  logic         combin_res,
    input  photon_t      photon,
    input  logic         photonValid,
    input  windows_t     windows,
    output coarseEvent_t coarseEvent,
    output fineEvent_t   fineEvent,
    output logic         eventValid
);

    // all ones marks a sample without photon
    localparam stamp_t EMPTY_STAMP = '1;

    logic       isPhoton;
    stamp_t     winLow;
    stamp_t     offset;
    logic       inWindow;
    coarseBin_t coarseBin;
    fineBin_t   fineBin;

    // **************************************************
    // bin derivation
    // **************************************************
    assign isPhoton = (photon.stamp != EMPTY_STAMP);

    // top bits give the coarse bin
    assign coarseBin = photon.stamp[`NP-1 -: `COARSE_W];

    // window of this pixel from the previous frame
    assign winLow = windows[photon.pixel];
    assign offset = photon.stamp - winLow;

    // low <= stamp < low + 64
    // checked on the offset so the upper bound cannot overflow
    assign inWindow = (photon.stamp >= winLow) && (offset < stamp_t'(`FINE_SPAN));

    // two stamps per fine bin
    assign fineBin = fineBin_t'(offset >> 1);

    // valid strobe shared by both events
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            eventValid <= 1'b0;
        end else begin
            eventValid <= photonValid;
        end
    end

    // event payloads
    // frameEnd travels even without a hit so the frame always closes
    always_ff @(posedge clk) begin
        if (photonValid) begin
            coarseEvent.hit      <= isPhoton;
            coarseEvent.pixel    <= photon.pixel;
            coarseEvent.bin      <= coarseBin;
            coarseEvent.frameEnd <= photon.frameEnd;

            fineEvent.hit      <= isPhoton && inWindow;
            fineEvent.pixel    <= photon.pixel;
            fineEvent.bin      <= fineBin;
            fineEvent.frameEnd <= photon.frameEnd;
        end
    end

endmodule

`default_nettype wire

// ==== logic/sifhPkg.sv ====
// SiFH types for stamps, pixels, bins, pipeline events and per-pixel arrays
`include "sifh_defs.svh"
`default_nettype none

package sifhPkg;

    // **************************************************
    // scalar types
    // **************************************************

    typedef logic [`NP-1:0]       stamp_t;
    typedef logic [`PIXEL_W-1:0]  pixelIdx_t;
    typedef logic [`COUNT_W-1:0]  count_t;
    typedef logic [`COARSE_W-1:0] coarseBin_t;
    typedef logic [`FINE_W-1:0]   fineBin_t;

    // **************************************************
    // pipeline payloads
    // **************************************************

    // one written sample tagged by the sequencer
    typedef struct packed {
        pixelIdx_t pixel;
        stamp_t    stamp;
        logic      frameEnd;
    } photon_t;

    // binned event for the coarse bank
    typedef struct packed {
        logic       hit;
        pixelIdx_t  pixel;
        coarseBin_t bin;
        logic       frameEnd;
    } coarseEvent_t;

    // same layout with the fine bin index
    typedef struct packed {
        logic      hit;
        pixelIdx_t pixel;
        fineBin_t  bin;
        logic      frameEnd;
    } fineEvent_t;

    // per-pixel arrays, index is the pixel number
    typedef coarseBin_t [`PIXEL_NUM-1:0] coarsePeaks_t;
    typedef fineBin_t   [`PIXEL_NUM-1:0] finePeaks_t;
    typedef stamp_t     [`PIXEL_NUM-1:0] windows_t;
    typedef stamp_t     [`PIXEL_NUM-1:0] results_t;

endpackage

`default_nettype wire

// ==== logic/sifhTop.sv ====
// SiFH top level of the two-pass histogram peak finder for time-of-flight pixels
`timescale 1ns/1ps
`include "sifh_defs.svh"
`default_nettype none

module sifhTop import sifhPkg::*; (
    input  logic     clk,
    input  logic     combin_res,
    input  logic     wrEn,
    input  stamp_t   data,
    output results_t result,
    output logic     resultValid
);

    // **************************************************
    // pipeline wires
    // **************************************************
    photon_t      photon;
    logic         photonValid;
    windows_t     windows;
    coarseEvent_t coarseEvent;
    fineEvent_t   fineEvent;
    logic         eventValid;
    coarsePeaks_t coarsePeaks;
    finePeaks_t   finePeaks;
    // both banks close the frame in the same cycle
    logic         coarsePeaksValid;

    // sample tagging
    frameSequencer frameSequencer_inst (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .data        (data),
        .photon      (photon),
        .photonValid (photonValid)
    );

    // empty filter and bin mapping
    photonBinner photonBinner_inst (
        .clk         (clk),
        .combin_res  (combin_res),
        .photon      (photon),
        .photonValid (photonValid),
        .windows     (windows),
        .coarseEvent (coarseEvent),
        .fineEvent   (fineEvent),
        .eventValid  (eventValid)
    );

    // coarse pass over the full range
    histBank #(
        .binIdx_t (coarseBin_t),
        .BIN_NUM  (1 << `COARSE_W)
    ) coarseBank (
        .clk        (clk),
        .combin_res (combin_res),
        .hit        (coarseEvent.hit),
        .pixel      (coarseEvent.pixel),
        .bin        (coarseEvent.bin),
        .frameEnd   (coarseEvent.frameEnd),
        .eventValid (eventValid),
        .peaks      (coarsePeaks),
        .peaksValid (coarsePeaksValid)
    );

    // fine pass inside the window
    histBank #(
        .binIdx_t (fineBin_t),
        .BIN_NUM  (1 << `FINE_W)
    ) fineBank (
        .clk        (clk),
        .combin_res (combin_res),
        .hit        (fineEvent.hit),
        .pixel      (fineEvent.pixel),
        .bin        (fineEvent.bin),
        .frameEnd   (fineEvent.frameEnd),
        .eventValid (eventValid),
        .peaks      (finePeaks),
        .peaksValid ()
    );

    // windows for the next frame and final stamps
    peakResolver peakResolver_inst (
        .clk         (clk),
        .combin_res  (combin_res),
        .coarsePeaks (coarsePeaks),
        .finePeaks   (finePeaks),
        .peaksValid  (coarsePeaksValid),
        .windows     (windows),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

`default_nettype wire

// ==== logic/sifh_defs.svh ====
// SiFH widths and frame geometry shared by the peak finder and its testbench
`ifndef SIFH_DEFS_SVH
`define SIFH_DEFS_SVH

// **************************************************
// timestamp and frame geometry
// **************************************************

// timestamp width in bits
`define NP 8

// pixels per group and pixel index width
`define PIXEL_NUM 4
`define PIXEL_W 2

// samples per pixel in one acquisition
`define DATA_NUM 4
`define SAMPLE_W 2

// acquisitions per frame
`define ACQ_NUM 8
`define ACQ_W 3

// **************************************************
// histogram geometry
// **************************************************

// 8 coarse bins of 32 stamps
`define COARSE_W 3
`define COARSE_SPAN 32

// 32 fine bins of 2 stamps
`define FINE_W 5
`define FINE_SPAN 64

// enough for ACQ_NUM * DATA_NUM hits in one bin
`define COUNT_W 6

// highest legal window low
`define WINDOW_MAX 192

`endif

// ==== run.sh ====
#!/bin/sh
# build and run the SiFH testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module sifhTb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

# a failing bound assertion must not stop the run before the testbench reports it
./obj_dir/VsifhTb +verilator+error+limit+10
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

echo "simulation finished"
exit 0

// ==== sim/sifhTb.sv ====
// SiFH testbench: clustered time-of-flight frames checked against a reference model
`timescale 1ns/1ps
`include "sifh_defs.svh"
`default_nettype none

module sifhTb import sifhPkg::*; ();

    localparam int FRAME_NUM  = 12;
    localparam int SAMPLE_NUM = `ACQ_NUM * `PIXEL_NUM * `DATA_NUM;
    localparam int CLK_PERIOD = 4;
    // idle between frames, windows reload 3 cycles after the last sample
    localparam int FRAME_GAP  = 5;
    // two cycles per sample covers idle runs and frame gaps
    localparam int WATCHDOG_CYCLES = FRAME_NUM * SAMPLE_NUM * 2 + 200;

    logic     clk;
    logic     combin_res;
    logic     wrEn;
    stamp_t   data;
    results_t result;
    logic     resultValid;

    // samples of one frame in arrival order
    stamp_t   frameBuf [SAMPLE_NUM];
    // cluster centre per pixel, renewed every second frame
    int       centres [`PIXEL_NUM];
    // model state and expected results per frame
    stamp_t   modelWin [`PIXEL_NUM];
    results_t expTable [FRAME_NUM];
    int       framesModeled = 0;
    int       checkedCount  = 0;

    tbClock #(.HALF_PERIOD(CLK_PERIOD / 2), .RESET_CYCLES(2)) tbClock_inst (
        .clk        (clk),
        .combin_res (combin_res)
    );

    sifhTop sifhTop_inst (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .data        (data),
        .result      (result),
        .resultValid (resultValid)
    );

    bind sifhTop sifhAssert sifhAssert_inst (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .data        (data),
        .photon      (photon),
        .photonValid (photonValid),
        .resultValid (resultValid)
    );

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // one sample: empty, background or near the cluster centre
    function automatic stamp_t genStamp(input int centre);
        int kind;
        int v;
        kind = int'($urandom % 8);
        if (kind == 0) begin
            return '1;
        end
        if (kind == 1) begin
            v = int'($urandom % 255);
        end else begin
            v = centre + int'($urandom % 9) - 4;
        end
        // 255 would read as empty
        if (v < 0) v = 0;
        if (v > 254) v = 254;
        return stamp_t'(v);
    endfunction

    // frames 2,3 6,7 10,11 sit on the stamp range edges
    task automatic buildFrame(input int f);
        int p;
        if ((f % 2) == 0) begin
            for (p = 0; p < `PIXEL_NUM; p++) begin
                if ((f % 4) >= 2) begin
                    centres[p] = (p < 2) ? int'($urandom % 8) : 247 + int'($urandom % 8);
                end else begin
                    centres[p] = 8 + int'($urandom % 240);
                end
            end
        end
        for (int i = 0; i < SAMPLE_NUM; i++) begin
            p = (i / `DATA_NUM) % `PIXEL_NUM;
            frameBuf[i] = genStamp(centres[p]);
        end
    endtask

    // **************************************************
    // reference model
    // **************************************************
    task automatic modelFrame(input int f);
        int       cCnt [`PIXEL_NUM][8] = '{default: 0};
        int       fCnt [`PIXEL_NUM][32] = '{default: 0};
        int       cMax [`PIXEL_NUM] = '{default: 0};
        int       fMax [`PIXEL_NUM] = '{default: 0};
        int       cPeak [`PIXEL_NUM] = '{default: 0};
        int       fPeak [`PIXEL_NUM] = '{default: 0};
        int       p;
        int       s;
        int       b;
        int       off;
        int       low;
        results_t frameResult;
        for (int i = 0; i < SAMPLE_NUM; i++) begin
            p   = (i / `DATA_NUM) % `PIXEL_NUM;
            s   = int'(frameBuf[i]);
            off = s - int'(modelWin[p]);
            if (s != 255) begin
                // coarse bin is stamp / 32, first strict maximum wins
                b = s / 32;
                cCnt[p][b]++;
                if (cCnt[p][b] > cMax[p]) begin
                    cMax[p]  = cCnt[p][b];
                    cPeak[p] = b;
                end
                // fine pass only inside [low, low + 64)
                if (off >= 0 && off < 64) begin
                    b = off / 2;
                    fCnt[p][b]++;
                    if (fCnt[p][b] > fMax[p]) begin
                        fMax[p]  = fCnt[p][b];
                        fPeak[p] = b;
                    end
                end
            end
        end
        for (p = 0; p < `PIXEL_NUM; p++) begin
            frameResult[p] = stamp_t'(int'(modelWin[p]) + 2 * fPeak[p] + 1);
            // next window, coarse centre minus 32 clamped to 0..192
            low = cPeak[p] * 32 + 16 - 32;
            if (low < 0) low = 0;
            if (low > 192) low = 192;
            modelWin[p] = stamp_t'(low);
        end
        expTable[f] = frameResult;
    endtask

    // samples on falling edges with random idle runs
    task automatic driveFrame();
        int idle;
        int budget;
        budget = 64;
        for (int i = 0; i < SAMPLE_NUM; i++) begin
            if (budget > 0 && ($urandom % 8) == 0) begin
                idle   = 1 + int'($urandom % 3);
                budget = budget - idle;
                repeat (idle) begin
                    wrEn = 1'b0;
                    data = stamp_t'($urandom);
                    @(negedge clk);
                end
            end
            wrEn = 1'b1;
            data = frameBuf[i];
            @(negedge clk);
        end
        wrEn = 1'b0;
        repeat (FRAME_GAP) @(negedge clk);
    endtask

    // result check on every pulse, frame 0 never pulses
    always @(negedge clk) begin
        if (combin_res && resultValid) begin
            if (checkedCount + 1 >= framesModeled) begin
                abortRun("result pulse arrived with no frame pending");
            end else begin
                for (int p = 0; p < `PIXEL_NUM; p++) begin
                    assert (result[p] == expTable[checkedCount + 1][p]) else begin
                        abortRun($sformatf("[ERROR] result pixel %0d expected 0x%02h actual 0x%02h",
                            p, expTable[checkedCount + 1][p], result[p]));
                    end
                end
                checkedCount <= checkedCount + 1;
            end
        end
    end

    // bound assertions raise a flag
    always @(negedge clk) begin
        if (sifhTop_inst.sifhAssert_inst.anyFail) begin
            abortRun("a concurrent assertion on the DUT failed");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abortRun("watchdog expired before all frames were checked");
    end

    initial begin
        void'($urandom(67853));
        wrEn = 1'b0;
        data = '0;
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            modelWin[p] = '0;
        end
        @(posedge combin_res);
        @(negedge clk);
        for (int f = 0; f < FRAME_NUM; f++) begin
            buildFrame(f);
            modelFrame(f);
            framesModeled = f + 1;
            driveFrame();
        end
        while (checkedCount < FRAME_NUM - 1) @(negedge clk);
        repeat (FRAME_GAP) @(negedge clk);
        if (checkedCount == FRAME_NUM - 1) begin
            $display("TB PASSED");
            $finish;
        end else begin
            abortRun("number of checked frames does not match the frames sent");
        end
    end

endmodule

`default_nettype wire

// ==== sim/sifh_assert.sv ====
// SiFH protocol and result timing assertions bound into the top level
`timescale 1ns/1ps
`default_nettype none

module sifhAssert import sifhPkg::*; (
    input logic    clk,
    input logic    combin_res,
    input logic    wrEn,
    input stamp_t  data,
    input photon_t photon,
    input logic    photonValid,
    input logic    resultValid
);

    // frame end at the sequencer output, one cycle after the sample
    logic       frameClose;
    // frames closed since reset, saturates at two
    logic [1:0] framesSeen;

    // sticky flags, one per assertion
    logic captureFail = 1'b0;
    logic quietFail   = 1'b0;
    logic timingFail  = 1'b0;
    logic originFail  = 1'b0;
    logic pulseFail   = 1'b0;
    logic anyFail;

    assign frameClose = photonValid && photon.frameEnd;
    assign anyFail    = captureFail || quietFail || timingFail || originFail || pulseFail;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            framesSeen <= '0;
        end else if (frameClose && (framesSeen != 2'd2)) begin
            framesSeen <= framesSeen + 1'b1;
        end
    end

    // **************************************************
    // capture and result timing
    // **************************************************

    // every write reaches the sequencer register
    captureChk: assert property (@(posedge clk) disable iff (!combin_res)
        wrEn |=> photonValid && (photon.stamp == $past(data)))
    else begin
        $error("sequencer did not register a written sample");
        captureFail = 1'b1;
    end

    // no result for the first frame, it had no window
    quietChk: assert property (@(posedge clk) disable iff (!combin_res)
        (framesSeen != 2'd2) |-> !resultValid)
    else begin
        $error("result pulse before the second frame closed");
        quietFail = 1'b1;
    end

    // frame close plus 3 is sample edge plus 4
    timingChk: assert property (@(posedge clk) disable iff (!combin_res)
        ($past(frameClose, 3) && (framesSeen == 2'd2)) |-> resultValid)
    else begin
        $error("result pulse missing 4 cycles after the frame end");
        timingFail = 1'b1;
    end

    // a pulse only ever follows a frame end
    originChk: assert property (@(posedge clk) disable iff (!combin_res)
        resultValid |-> $past(frameClose, 3))
    else begin
        $error("result pulse without a matching frame end");
        originFail = 1'b1;
    end

    // one cycle wide
    pulseChk: assert property (@(posedge clk) disable iff (!combin_res)
        resultValid |=> !resultValid)
    else begin
        $error("result pulse longer than one cycle");
        pulseFail = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/tbClock.sv ====
// SiFH testbench clock and active-low reset generator
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic combin_res
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset over RESET_CYCLES rising edges
    // released on a falling edge, away from the DUT flops
    initial begin
        combin_res = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        combin_res = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+logic
logic/sifhPkg.sv
logic/frameSequencer.sv
logic/photonBinner.sv
logic/histBank.sv
logic/peakResolver.sv
logic/sifhTop.sv
sim/tbClock.sv
sim/sifh_assert.sv
sim/sifhTb.sv
